/* cpu_pkg.sv */
package cpu_pkg;

    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } insn_i_t;

    // One instruction word, two field layouts
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef struct packed {
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        op_e         op;
        logic        use_imm;
        logic [31:0] imm;
    } decoded_t;

endpackage

/* insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder (
    input  logic              clk,
    input  logic              i_valid,
    input  cpu_pkg::insn_u    i_insn,
    output cpu_pkg::decoded_t o_decoded
);
    import cpu_pkg::*;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

    logic supported;

    // Shared funct3 map of OP and OP-IMM, returns 0 for encodings outside the subset
    function automatic logic f3_decode(input logic [2:0] funct3, output op_e op);
        logic ok;
        ok = 1'b1;
        case (funct3)
            3'b000:  op = OP_ADD;
            3'b100:  op = OP_XOR;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: begin
                op = OP_ADD;
                ok = 1'b0;
            end
        endcase
        return ok;
    endfunction

    always_comb begin
        o_decoded = '0;
        supported = 1'b0;
        o_decoded.rd  = i_insn.r.rd;
        o_decoded.rs1 = i_insn.r.rs1;
        case (i_insn.r.opcode)
            OPC_OP: begin
                o_decoded.rs2 = i_insn.r.rs2;
                if (i_insn.r.funct7 == FUNCT7_MULDIV) begin
                    o_decoded.op = OP_MUL;
                    supported = i_insn.r.funct3 == 3'b000;
                end else if (i_insn.r.funct7 == FUNCT7_SUB) begin
                    o_decoded.op = OP_SUB;
                    supported = i_insn.r.funct3 == 3'b000;
                end else begin
                    supported = f3_decode(i_insn.r.funct3, o_decoded.op) &&
                                i_insn.r.funct7 == FUNCT7_BASE;
                end
            end
            OPC_OP_IMM: begin
                // rs2 stays x0 so no bypass or stall is raised for it
                o_decoded.use_imm = 1'b1;
                o_decoded.imm = {{20{i_insn.i.imm12[11]}}, i_insn.i.imm12};
                supported = f3_decode(i_insn.i.funct3, o_decoded.op);
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) i_valid |-> supported)
        else $error("unsupported instruction word %h", i_insn);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  cpu_pkg::reg_idx_t   i_ra_sel,
    input  cpu_pkg::reg_idx_t   i_rb_sel,
    output logic [XLEN-1:0]     o_ra_data,
    output logic [XLEN-1:0]     o_rb_data,
    input  logic                i_w_en,
    input  cpu_pkg::reg_idx_t   i_w_sel,
    input  logic [XLEN-1:0]     i_w_data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs[i_w_sel] <= i_w_data;
        end
    end

    assign o_ra_data = (i_ra_sel == '0) ? '0 : regs[i_ra_sel];
    assign o_rb_data = (i_rb_sel == '0) ? '0 : regs[i_rb_sel];

endmodule

/* operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass #(
    parameter int XLEN = 32
) (
    input  cpu_pkg::decoded_t   i_decoded,
    input  logic [XLEN-1:0]     i_rf_rs1,
    input  logic [XLEN-1:0]     i_rf_rs2,
    input  logic                i_ex1_pending,
    input  logic                i_ex1_value_valid,
    input  cpu_pkg::reg_idx_t   i_ex1_rd,
    input  logic [XLEN-1:0]     i_ex1_data,
    input  logic                i_ex2_pending,
    input  logic                i_ex2_data_valid,
    input  cpu_pkg::reg_idx_t   i_ex2_rd,
    input  logic [XLEN-1:0]     i_ex2_data,
    output logic [XLEN-1:0]     o_rs1,
    output logic [XLEN-1:0]     o_rs2,
    output logic                o_stall
);
    import cpu_pkg::*;

    // Returns {stall, value}; the EX1 producer is younger and wins
    function automatic logic [XLEN:0] resolve(input reg_idx_t src, input logic [XLEN-1:0] rf);
        logic [XLEN-1:0] val;
        logic            stall;
        val = rf;
        stall = 1'b0;
        if (src != '0 && i_ex1_pending && i_ex1_rd == src) begin
            val = i_ex1_data;
            stall = !i_ex1_value_valid;
        end else if (src != '0 && i_ex2_pending && i_ex2_rd == src) begin
            val = i_ex2_data;
            stall = !i_ex2_data_valid;
        end
        return {stall, val};
    endfunction

    logic [XLEN:0] res1;
    logic [XLEN:0] res2;

    // Producer state is read inside resolve
    always_comb begin
        res1 = resolve(i_decoded.rs1, i_rf_rs1);
        res2 = resolve(i_decoded.rs2, i_rf_rs2);
    end

    assign o_rs1   = res1[XLEN-1:0];
    assign o_rs2   = res2[XLEN-1:0];
    assign o_stall = res1[XLEN] || res2[XLEN];

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_valid,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic            o_valid,
    output logic [XLEN-1:0] o_value
);

    localparam int CW = $clog2(XLEN);

    logic            busy;
    logic [CW-1:0]   count;
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy    <= 1'b0;
            count   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (i_valid) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                // Last bit consumed
                if (count == CW'(XLEN - 1)) begin
                    busy    <= 1'b0;
                    o_valid <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle, product truncated to XLEN
    always_ff @(posedge clk) begin
        if (i_valid) begin
            acc    <= '0;
            mcand  <= i_a;
            mplier <= i_b;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign o_value = acc;

endmodule

/* stage_ex1.sv */
`timescale 1ns/1ps

module stage_ex1 #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  cpu_pkg::decoded_t   i_decoded,
    input  logic                i_de_valid,
    output logic                o_de_ready,
    output cpu_pkg::reg_idx_t   o_rs1_sel,
    output cpu_pkg::reg_idx_t   o_rs2_sel,
    output cpu_pkg::decoded_t   o_de_decoded,
    input  logic [XLEN-1:0]     i_rs1,
    input  logic [XLEN-1:0]     i_rs2,
    input  logic                i_stall,
    input  logic                i_ex2_ready,
    output logic                o_ex1_valid,
    output logic                o_ex1_value_valid,
    output cpu_pkg::decoded_t   o_ex1_decoded,
    output logic [XLEN-1:0]     o_ex1_data,
    output logic [XLEN-1:0]     o_ex1_data2
);
    import cpu_pkg::*;

    logic            de_valid;
    decoded_t        de_q;
    logic            issue;
    logic            transfer;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] alu_res;

    assign transfer   = o_ex1_valid && i_ex2_ready;
    assign issue      = de_valid && !i_stall && (!o_ex1_valid || i_ex2_ready);
    assign o_de_ready = !de_valid || issue;

    // Read selects come straight from the DE-EX register
    assign o_rs1_sel    = de_q.rs1;
    assign o_rs2_sel    = de_q.rs2;
    assign o_de_decoded = de_q;

    assign opb = de_q.use_imm ? XLEN'($signed(de_q.imm)) : i_rs2;

    always_comb begin
        case (de_q.op)
            OP_SUB:  alu_res = i_rs1 - opb;
            OP_AND:  alu_res = i_rs1 & opb;
            OP_OR:   alu_res = i_rs1 | opb;
            OP_XOR:  alu_res = i_rs1 ^ opb;
            // MUL passes operand a on to EX2
            OP_MUL:  alu_res = i_rs1;
            default: alu_res = i_rs1 + opb;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            de_valid          <= 1'b0;
            o_ex1_valid       <= 1'b0;
            o_ex1_value_valid <= 1'b0;
        end else begin
            if (i_de_valid && o_de_ready) begin
                de_valid <= 1'b1;
            end else if (issue) begin
                de_valid <= 1'b0;
            end
            if (transfer) begin
                o_ex1_valid       <= 1'b0;
                o_ex1_value_valid <= 1'b0;
            end
            if (issue) begin
                o_ex1_valid       <= 1'b1;
                o_ex1_value_valid <= de_q.op != OP_MUL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_de_valid && o_de_ready) begin
            de_q <= i_decoded;
        end
        if (issue) begin
            o_ex1_decoded <= de_q;
            o_ex1_data    <= alu_res;
            o_ex1_data2   <= opb;
        end
    end

    // A held EX1-EX2 entry must keep its contents until EX2 takes it
    assert property (@(posedge clk) disable iff (!resetn)
        o_ex1_valid && !i_ex2_ready |=> o_ex1_valid && $stable(o_ex1_data)
                                        && $stable(o_ex1_decoded))
        else $error("EX1-EX2 register overwritten while full");

endmodule

/* stage_ex2.sv */
`timescale 1ns/1ps

module stage_ex2 #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                i_ex1_valid,
    input  logic                i_ex1_value_valid,
    input  cpu_pkg::decoded_t   i_ex1_decoded,
    input  logic [XLEN-1:0]     i_ex1_data,
    input  logic [XLEN-1:0]     i_ex1_data2,
    output logic                o_ex2_ready,
    output logic                o_pending,
    output logic                o_data_valid,
    output cpu_pkg::reg_idx_t   o_rd,
    output logic [XLEN-1:0]     o_data
);

    logic            transfer;
    logic            is_mul;
    logic            alu_valid;
    logic [XLEN-1:0] alu_data;
    logic            mul_start;
    logic            mul_valid;
    logic [XLEN-1:0] mul_data;

    assign o_ex2_ready = !o_pending || o_data_valid;
    assign transfer    = i_ex1_valid && o_ex2_ready;
    // EX1 leaves value_valid low only for MUL
    assign mul_start   = transfer && !i_ex1_value_valid;

    mul_unit #(
        .XLEN (XLEN)
    ) mul_i (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (mul_start),
        .i_a     (i_ex1_data),
        .i_b     (i_ex1_data2),
        .o_valid (mul_valid),
        .o_value (mul_data)
    );

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_pending <= 1'b0;
            is_mul    <= 1'b0;
            alu_valid <= 1'b0;
        end else if (transfer) begin
            o_pending <= 1'b1;
            is_mul    <= !i_ex1_value_valid;
            alu_valid <= i_ex1_value_valid;
        end else if (o_data_valid) begin
            o_pending <= 1'b0;
            is_mul    <= 1'b0;
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            o_rd     <= i_ex1_decoded.rd;
            alu_data <= i_ex1_data;
        end
    end

    assign o_data_valid = is_mul ? mul_valid : alu_valid;
    assign o_data       = is_mul ? mul_data : alu_data;

    assert property (@(posedge clk) disable iff (!resetn) mul_start |-> !mul_i.busy)
        else $error("multiplier started while busy");

endmodule

/* exec_core.sv */
`timescale 1ns/1ps

module exec_core #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                i_insn_valid,
    input  cpu_pkg::insn_u      i_insn,
    output logic                o_insn_ready,
    output logic                o_wb_valid,
    output cpu_pkg::reg_idx_t   o_wb_rd,
    output logic [XLEN-1:0]     o_wb_data
);
    import cpu_pkg::*;

    decoded_t        dec_word;
    decoded_t        de_decoded;
    reg_idx_t        rs1_sel;
    reg_idx_t        rs2_sel;
    logic [XLEN-1:0] rf_rs1;
    logic [XLEN-1:0] rf_rs2;
    logic [XLEN-1:0] byp_rs1;
    logic [XLEN-1:0] byp_rs2;
    logic            stall;
    logic            ex1_valid;
    logic            ex1_value_valid;
    decoded_t        ex1_decoded;
    logic [XLEN-1:0] ex1_data;
    logic [XLEN-1:0] ex1_data2;
    logic            ex2_ready;
    logic            ex2_pending;
    logic            ex2_data_valid;

    assign o_wb_valid = ex2_pending && ex2_data_valid;

    insn_decoder decoder_i (
        .clk       (clk),
        .i_valid   (i_insn_valid),
        .i_insn    (i_insn),
        .o_decoded (dec_word)
    );

    reg_file #(
        .XLEN (XLEN)
    ) regfile_i (
        .clk       (clk),
        .resetn    (resetn),
        .i_ra_sel  (rs1_sel),
        .i_rb_sel  (rs2_sel),
        .o_ra_data (rf_rs1),
        .o_rb_data (rf_rs2),
        .i_w_en    (o_wb_valid),
        .i_w_sel   (o_wb_rd),
        .i_w_data  (o_wb_data)
    );

    stage_ex1 #(
        .XLEN (XLEN)
    ) ex1_i (
        .clk               (clk),
        .resetn            (resetn),
        .i_decoded         (dec_word),
        .i_de_valid        (i_insn_valid),
        .o_de_ready        (o_insn_ready),
        .o_rs1_sel         (rs1_sel),
        .o_rs2_sel         (rs2_sel),
        .o_de_decoded      (de_decoded),
        .i_rs1             (byp_rs1),
        .i_rs2             (byp_rs2),
        .i_stall           (stall),
        .i_ex2_ready       (ex2_ready),
        .o_ex1_valid       (ex1_valid),
        .o_ex1_value_valid (ex1_value_valid),
        .o_ex1_decoded     (ex1_decoded),
        .o_ex1_data        (ex1_data),
        .o_ex1_data2       (ex1_data2)
    );

    operand_bypass #(
        .XLEN (XLEN)
    ) bypass_i (
        .i_decoded         (de_decoded),
        .i_rf_rs1          (rf_rs1),
        .i_rf_rs2          (rf_rs2),
        .i_ex1_pending     (ex1_valid),
        .i_ex1_value_valid (ex1_value_valid),
        .i_ex1_rd          (ex1_decoded.rd),
        .i_ex1_data        (ex1_data),
        .i_ex2_pending     (ex2_pending),
        .i_ex2_data_valid  (ex2_data_valid),
        .i_ex2_rd          (o_wb_rd),
        .i_ex2_data        (o_wb_data),
        .o_rs1             (byp_rs1),
        .o_rs2             (byp_rs2),
        .o_stall           (stall)
    );

    stage_ex2 #(
        .XLEN (XLEN)
    ) ex2_i (
        .clk               (clk),
        .resetn            (resetn),
        .i_ex1_valid       (ex1_valid),
        .i_ex1_value_valid (ex1_value_valid),
        .i_ex1_decoded     (ex1_decoded),
        .i_ex1_data        (ex1_data),
        .i_ex1_data2       (ex1_data2),
        .o_ex2_ready       (ex2_ready),
        .o_pending         (ex2_pending),
        .o_data_valid      (ex2_data_valid),
        .o_rd              (o_wb_rd),
        .o_data            (o_wb_data)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

/* tb_exec_core.sv */
`timescale 1ns/1ps

module tb_exec_core;
    import cpu_pkg::*;

    localparam int          XLEN        = 32;
    localparam int          MAX_ENTRIES = 64;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;
    localparam logic [16:0] LFSR_SEED   = 17'd77767;

    logic            clk;
    logic            resetn;
    logic            i_insn_valid;
    insn_u           i_insn;
    logic            o_insn_ready;
    logic            o_wb_valid;
    reg_idx_t        o_wb_rd;
    logic [XLEN-1:0] o_wb_data;

    // Three words per entry: instruction, rd, value
    logic [31:0] vectors [0:3*MAX_ENTRIES-1];
    int          n_entries = 0;
    int          wb_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [16:0] lfsr_state = LFSR_SEED;

    tb_clock #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (4)
    ) clock_i (
        .clk    (clk),
        .resetn (resetn)
    );

    exec_core #(
        .XLEN (XLEN)
    ) dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .o_insn_ready (o_insn_ready),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic int count_entries();
        int k;
        k = 0;
        while (k < MAX_ENTRIES && vectors[3*k] != END_MARK) begin
            k++;
        end
        return k;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        $display("Test failed");
        $fatal(1, "mismatch in %s", name);
    endtask

    task automatic check_writeback(input int k);
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        string       name;
        if (k >= n_entries) begin
            abort_run($sformatf("Extra writeback to x%0d after all %0d results were seen",
                                o_wb_rd, n_entries));
        end else begin
            exp_rd   = vectors[3*k+1][4:0];
            exp_data = vectors[3*k+2];
            name     = $sformatf("insn %0d (%h)", k, vectors[3*k]);
            assert (o_wb_rd == exp_rd)
                else report_mismatch({name, " rd"}, 32'(exp_rd), 32'(o_wb_rd));
            assert (o_wb_data == exp_data)
                else report_mismatch({name, " data"}, exp_data, o_wb_data);
        end
    endtask

    // Outputs come from registers and are sampled mid-cycle
    always @(negedge clk) begin
        if (resetn && o_wb_valid) begin
            check_writeback(wb_count);
            wb_count = wb_count + 1;
        end
    end

    always @(posedge clk) begin
        if (resetn) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                                    cycle_count, wb_count, n_entries));
            end
        end
    end

    initial begin
        int pick;
        int gap;
        i_insn_valid = 1'b0;
        i_insn       = '0;
        for (int k = 0; k < 3*MAX_ENTRIES; k++) begin
            vectors[k] = END_MARK;
        end
        $readmemh("test_input.txt", vectors);
        n_entries   = count_entries();
        cycle_limit = n_entries * (XLEN + 8) + 100;
        if (n_entries == 0) begin
            abort_run("No entries found in test_input.txt");
        end

        wait (resetn === 1'b1);
        // Idle core right after reset
        repeat (2) begin
            @(negedge clk);
            assert (!o_wb_valid && o_insn_ready)
                else abort_run("Core not idle after reset");
        end
        @(posedge clk);

        for (int k = 0; k < n_entries; k++) begin
            draw_bits(2, pick);
            gap = (pick >= 2) ? pick - 1 : 0;
            if (gap > 0) begin
                i_insn_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            i_insn_valid <= 1'b1;
            i_insn       <= vectors[3*k];
            // Hold the word until the core takes it
            @(negedge clk);
            while (!o_insn_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        i_insn_valid <= 1'b0;

        wait (wb_count == n_entries);
        repeat (5) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* test_input.txt */
// Instruction word then expected rd and writeback value, all hex
// Registers start at zero
00500093 01 00000005
ffd00113 02 fffffffd
fff0c193 03 fffffffa
0f017213 04 000000f0
70f26293 05 000007ff
00228333 06 000007fc
401303b3 07 000007f7
0033f433 08 000007f2
006464b3 09 000007fe
0074c533 0a 00000009
022505b3 0b ffffffe5
00158633 0c ffffffea
025286b3 0d 003ff001
1230c713 0e 00000126
00708013 00 0000000c
00e007b3 0f 00000126
80006813 10 fffff800
40d808b3 11 ffc007ff

/* filelist.f */
cpu_pkg.sv
insn_decoder.sv
reg_file.sv
operand_bypass.sv
mul_unit.sv
stage_ex1.sv
stage_ex2.sv
exec_core.sv
tb_clock.sv
tb_exec_core.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_exec_core -f filelist.f \
    -Mdir obj_dir -o tb_exec_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
